// File: logic/mini_core_pkg.sv
package mini_core_pkg;

    // architectural register width
    localparam int unsigned xlen = 32;

    // one extra bit so unsigned operands fit a signed datapath
    localparam int unsigned op_w = xlen + 1;

    // radix-2 Booth retires one multiplier bit per stage
    localparam int unsigned n_stages = op_w;

    // full signed product of two op_w-bit operands
    localparam int unsigned prod_w = 2 * op_w;

    // working word laid out as {A, Q, Q-1}
    localparam int unsigned acc_w = 2 * op_w + 1;

    // RISC-V M-extension multiply group
    typedef enum logic [1:0] {
        op_mul    = 2'b00,
        op_mulh   = 2'b01,
        op_mulhsu = 2'b10,
        op_mulhu  = 2'b11
    } mul_op_e;

    // request as it arrives from the issue stage
    typedef struct packed {
        mul_op_e          op;
        logic [xlen-1:0]  rs1;
        logic [xlen-1:0]  rs2;
    } mul_req_t;

    // one item in flight between pipeline stages
    typedef struct packed {
        logic             valid;
        mul_op_e          op;
        logic [op_w-1:0]  m;
        logic [acc_w-1:0] acc;
    } booth_stage_t;

    // rs1 is signed for everything except mulhu
    function automatic logic rs1_is_signed(mul_op_e op);
        logic sgn;
        case (op)
            op_mulhu: sgn = 1'b0;
            default:  sgn = 1'b1;
        endcase
        return sgn;
    endfunction

    // rs2 is signed only for mul and mulh
    function automatic logic rs2_is_signed(mul_op_e op);
        logic sgn;
        case (op)
            op_mul, op_mulh: sgn = 1'b1;
            default:         sgn = 1'b0;
        endcase
        return sgn;
    endfunction

    // widen an operand by one bit, copying the sign or inserting zero
    function automatic logic [op_w-1:0] extend_operand(logic [xlen-1:0] v, logic sgn);
        logic top;
        top = sgn & v[xlen-1];
        return {top, v};
    endfunction

endpackage

// File: logic/mini_core_booth_operand_prep.sv
`timescale 1ns/100ps

module mini_core_booth_operand_prep
    import mini_core_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid,
    input  mul_req_t     req,
    output booth_stage_t stage_out
);

    logic             rs1_sgn;
    logic             rs2_sgn;
    logic [op_w-1:0]  m_ext;
    logic [op_w-1:0]  q_ext;
    logic [acc_w-1:0] acc_init;

    // signedness follows the opcode of this request only
    always_comb begin
        rs1_sgn = rs1_is_signed(req.op);
        rs2_sgn = rs2_is_signed(req.op);
    end

    // rs1 becomes the multiplicand, rs2 the multiplier
    always_comb begin
        m_ext = extend_operand(req.rs1, rs1_sgn);
        q_ext = extend_operand(req.rs2, rs2_sgn);
    end

    // A starts at zero, Q holds the multiplier, Q-1 is zero
    always_comb begin
        acc_init = {{op_w{1'b0}}, q_ext, 1'b0};
    end

    // a bubble still advances so every item keeps its slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_out.valid <= 1'b0;
            stage_out.op    <= op_mul;
            stage_out.m     <= '0;
            stage_out.acc   <= '0;
        end else begin
            stage_out.valid <= req_valid;
            stage_out.op    <= req.op;
            stage_out.m     <= m_ext;
            stage_out.acc   <= acc_init;
        end
    end

    // an unknown opcode would pick the wrong extension and result half downstream
    assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !$isunknown(req.op))
        else $error("multiplier request with unknown opcode");

endmodule

// File: logic/mini_core_booth_step.sv
`timescale 1ns/100ps

module mini_core_booth_step
    import mini_core_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  booth_stage_t stage_in,
    output booth_stage_t stage_out
);

    logic [op_w-1:0]  a_cur;
    logic [op_w-1:0]  m_cur;
    logic [1:0]       booth_pair;
    logic [op_w:0]    a_sum;
    logic [acc_w:0]   wide;
    logic [acc_w-1:0] acc_next;

    // split the working word
    always_comb begin
        a_cur      = stage_in.acc[acc_w-1 -: op_w];
        m_cur      = stage_in.m;
        booth_pair = stage_in.acc[1:0];
    end

    // Q0 and Q-1 decide the partial product
    // A is widened by one sign bit so the sum cannot wrap before the shift
    always_comb begin
        case (booth_pair)
            2'b01: begin
                a_sum = {a_cur[op_w-1], a_cur} + {m_cur[op_w-1], m_cur};
            end
            2'b10: begin
                a_sum = {a_cur[op_w-1], a_cur} - {m_cur[op_w-1], m_cur};
            end
            default: begin
                a_sum = {a_cur[op_w-1], a_cur};
            end
        endcase
    end

    // arithmetic shift right by one across A, Q and Q-1
    // the guard bit of the sum becomes the new sign of A
    always_comb begin
        wide     = {a_sum, stage_in.acc[acc_w-op_w-1:0]};
        acc_next = wide[acc_w:1];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_out.valid <= 1'b0;
            stage_out.op    <= op_mul;
            stage_out.m     <= '0;
            stage_out.acc   <= '0;
        end else begin
            stage_out.valid <= stage_in.valid;
            stage_out.op    <= stage_in.op;
            stage_out.m     <= stage_in.m;
            stage_out.acc   <= acc_next;
        end
    end

    // no stage may create or swallow an item
    assert property (@(posedge clk) disable iff (rst)
        stage_out.valid == $past(stage_in.valid))
        else $error("booth stage dropped or duplicated a valid item");

endmodule

// File: logic/mini_core_booth_result_select.sv
`timescale 1ns/100ps

module mini_core_booth_result_select
    import mini_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  booth_stage_t    stage_in,
    output logic            res_valid,
    output logic [xlen-1:0] res
);

    logic [prod_w-1:0] product;
    logic [xlen-1:0]   res_lo;
    logic [xlen-1:0]   res_hi;
    logic [xlen-1:0]   res_next;

    // product sits above the Q-1 bit after the last step
    always_comb begin
        product = stage_in.acc[acc_w-1:1];
    end

    // the two top product bits only matter for the extension and are dropped
    always_comb begin
        res_lo = product[xlen-1:0];
        res_hi = product[2*xlen-1:xlen];
    end

    // mul wants the low word, the mulh group the high word
    always_comb begin
        case (stage_in.op)
            op_mul: begin
                res_next = res_lo;
            end
            default: begin
                res_next = res_hi;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= stage_in.valid;
            res       <= res_next;
        end
    end

    // an X here means a stage upstream passed garbage along with a valid item
    assert property (@(posedge clk) disable iff (rst)
        res_valid |-> !$isunknown(res))
        else $error("multiplier result has unknown bits while valid");

endmodule

// File: logic/mini_core_mul.sv
`timescale 1ns/100ps

module mini_core_mul
    import mini_core_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  mul_req_t        req,
    output logic            res_valid,
    output logic [xlen-1:0] res
);

    // stage 0 comes from prep, stage n_stages goes to result select
    booth_stage_t stage [0:n_stages];

    // one cycle to extend operands and build the initial word
    mini_core_booth_operand_prep u_prep (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .stage_out (stage[0])
    );

    // one multiplier bit retired per stage
    genvar k;
    generate
        for (k = 0; k < n_stages; k++) begin : g_step
            mini_core_booth_step u_step (
                .clk       (clk),
                .rst       (rst),
                .stage_in  (stage[k]),
                .stage_out (stage[k+1])
            );
        end
    endgenerate

    // one cycle to pick the product half
    mini_core_booth_result_select u_select (
        .clk       (clk),
        .rst       (rst),
        .stage_in  (stage[n_stages]),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// File: dv/mini_core_mul_tb.sv
`timescale 1ns/100ps

module mini_core_mul_tb
    import mini_core_pkg::*;
;

    // request to result, in clock edges
    localparam int unsigned lat = n_stages + 2;

    // test lengths
    localparam int unsigned idle_cycles    = lat + 5;
    localparam int unsigned n_random       = 400;
    localparam int unsigned n_corner       = 4 * 5 * 5;
    localparam int unsigned n_bubble_slots = 300;
    localparam int unsigned n_sign_pairs   = 8;
    localparam int unsigned n_drains       = 4;

    // reset, idle window, every driven slot, one drain per test, plus margin
    localparam int unsigned cycle_limit = 3 + idle_cycles + n_random + n_corner
        + n_bubble_slots + 4 * n_sign_pairs + n_drains * (lat + 4) + 50;

    // one expected result and the edge at which the DUT took its request
    typedef struct packed {
        logic [xlen-1:0] value;
        logic [31:0]     issue_cyc;
    } expected_t;

    logic            clk;
    logic            rst;
    logic            req_valid;
    mul_req_t        req;
    logic            res_valid;
    logic [xlen-1:0] res;

    expected_t       expected_q [$];
    expected_t       popped;
    logic [31:0]     rng_state;
    int unsigned     cyc;
    int unsigned     n_checks;
    int unsigned     n_errors;

    logic [xlen-1:0] corner [0:4];

    mini_core_mul dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    always #4 clk = ~clk;

    // classic 13/17/5 xorshift
    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // reference product with plain 64-bit signed arithmetic
    function automatic logic [xlen-1:0] model_result(mul_op_e op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
        logic                     a_sgn;
        logic                     b_sgn;
        logic signed [2*xlen-1:0] wa;
        logic signed [2*xlen-1:0] wb;
        logic signed [2*xlen-1:0] prod;
        a_sgn = (op != op_mulhu);
        b_sgn = (op == op_mul) || (op == op_mulh);
        if (a_sgn) begin
            wa = {{xlen{a[xlen-1]}}, a};
        end else begin
            wa = {{xlen{1'b0}}, a};
        end
        if (b_sgn) begin
            wb = {{xlen{b[xlen-1]}}, b};
        end else begin
            wb = {{xlen{1'b0}}, b};
        end
        // the low 64 bits are exact even for the unsigned case
        prod = wa * wb;
        if (op == op_mul) begin
            return prod[xlen-1:0];
        end
        return prod[2*xlen-1:xlen];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("error: time %0t %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // drive one slot, valid or bubble, and log what should come out
    task automatic issue_request(input logic v, input mul_op_e op,
                                 input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        mul_req_t  r;
        expected_t e;
        @(posedge clk);
        r.op  = op;
        r.rs1 = a;
        r.rs2 = b;
        req_valid <= v;
        req       <= r;
        if (v) begin
            e.value = model_result(op, a, b);
            // cyc once this drive edge has been counted, as the monitor sees it
            e.issue_cyc = cyc + 1;
            expected_q.push_back(e);
        end
    endtask

    task automatic random_request(input logic v);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = next_rand();
        a = next_rand();
        b = next_rand();
        issue_request(v, mul_op_e'(r[9:8]), a, b);
    endtask

    // results still missing after the pipeline depth stay in the queue
    task automatic wait_drain();
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (expected_q.size() != 0 && waited < lat + 4) begin
            @(negedge clk);
            waited++;
        end
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("timeout: cycle limit %0d reached with %0d results outstanding",
                     cycle_limit, expected_q.size());
            $display("checks %0d errors %0d", n_checks, n_errors);
            $display("tests failed");
            $finish;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            if (expected_q.size() == 0) begin
                n_errors++;
                $display("result appeared at time %0t with no request outstanding", $time);
            end else begin
                popped = expected_q.pop_front();
                check_value("res", popped.value, res);
                check_value("res_valid cycle", popped.issue_cyc + lat, cyc);
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        cyc       = 0;
        n_checks  = 0;
        n_errors  = 0;
        rng_state = 32'd91095;

        corner[0] = '0;
        corner[1] = 32'h0000_0001;
        corner[2] = '1;
        corner[3] = 32'h8000_0000;
        corner[4] = 32'h7fff_ffff;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet pipeline after reset
        for (int i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            check_value("res_valid", 0, res_valid);
        end

        // back to back random traffic
        for (int i = 0; i < n_random; i++) begin
            random_request(1'b1);
        end
        wait_drain();

        // every corner pairing under every opcode
        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_request(1'b1, mul_op_e'(o), corner[i], corner[j]);
                end
            end
        end
        wait_drain();

        // about 40% bubbles
        for (int i = 0; i < n_bubble_slots; i++) begin
            logic [31:0] r;
            r = next_rand();
            random_request((r % 10) >= 4);
        end
        wait_drain();

        // same negative pair under all four opcodes in a row
        for (int i = 0; i < n_sign_pairs; i++) begin
            logic [31:0] a;
            logic [31:0] b;
            a = next_rand() | 32'h8000_0000;
            b = next_rand() | 32'h8000_0000;
            issue_request(1'b1, op_mul, a, b);
            issue_request(1'b1, op_mulh, a, b);
            issue_request(1'b1, op_mulhsu, a, b);
            issue_request(1'b1, op_mulhu, a, b);
        end
        wait_drain();

        if (expected_q.size() != 0) begin
            n_errors++;
            $display("%0d expected results never came out of the DUT", expected_q.size());
        end

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: bender.yml
package:
  name: mini_core_mul

sources:
  - files:
      - logic/mini_core_pkg.sv
      - logic/mini_core_booth_operand_prep.sv
      - logic/mini_core_booth_step.sv
      - logic/mini_core_booth_result_select.sv
      - logic/mini_core_mul.sv
  - target: simulation
    files:
      - dv/mini_core_mul_tb.sv

// File: mini_core_mul.f
logic/mini_core_pkg.sv
logic/mini_core_booth_operand_prep.sv
logic/mini_core_booth_step.sv
logic/mini_core_booth_result_select.sv
logic/mini_core_mul.sv
dv/mini_core_mul_tb.sv
